// ==== Bender.yml ====
package:
  name: backend

sources:
  # Package and interfaces come first
  - design/backend_pkg.sv
  - design/backend_ifs.sv
  - design/issue_stage.sv
  - design/int_regfile.sv
  - design/alu_unit.sv
  - design/reorder_buffer.sv
  - design/backend.sv

  - target: simulation
    files:
      - sim/backend_asserts.sv
      - sim/tb_backend.sv

// ==== design/alu_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_unit #(
  parameter int unsigned ROB_DEPTH = 8
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  exec_if.alu                          exec_i,
  output logic                         cdb_valid_o,
  output logic [$clog2(ROB_DEPTH)-1:0] cdb_tag_o,
  output backend_pkg::xlen_t           cdb_value_o
);
  import backend_pkg::*;

  localparam int unsigned TAG_W = $clog2(ROB_DEPTH);

  logic             s1_valid_q;
  alu_op_e          s1_op_q;
  xlen_t            s1_a_q;
  xlen_t            s1_b_q;
  logic [TAG_W-1:0] s1_tag_q;

  logic [4:0]       shamt;
  xlen_t            result;

  // --------------------------------------------------
  // Stage 1: operand register
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s1_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= exec_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    s1_op_q  <= exec_i.op;
    s1_a_q   <= exec_i.operand_a;
    s1_b_q   <= exec_i.operand_b;
    s1_tag_q <= exec_i.tag;
  end

  // --------------------------------------------------
  // Stage 2: compute and drive the result bus
  // --------------------------------------------------
  assign shamt = s1_b_q[4:0];

  always_comb begin
    case (s1_op_q)
      ALU_ADD:    result = s1_a_q + s1_b_q;
      ALU_SUB:    result = s1_a_q - s1_b_q;
      ALU_SLT:    result = xlen_t'($signed(s1_a_q) < $signed(s1_b_q));
      ALU_XOR:    result = s1_a_q ^ s1_b_q;
      ALU_OR:     result = s1_a_q | s1_b_q;
      ALU_AND:    result = s1_a_q & s1_b_q;
      ALU_SLL:    result = s1_a_q << shamt;
      ALU_SRL:    result = s1_a_q >> shamt;
      ALU_PASS_B: result = s1_b_q;
      default:    result = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cdb_valid_o <= 1'b0;
    end else begin
      cdb_valid_o <= s1_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    cdb_tag_o   <= s1_tag_q;
    cdb_value_o <= result;
  end

endmodule

`default_nettype wire

// ==== design/backend.sv ====
`timescale 1ns/1ps
`default_nettype none

module backend #(
  parameter int unsigned ROB_DEPTH = 8
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  instr_valid_i,
  output logic                  instr_ready_o,
  input  backend_pkg::instr_t   instr_i,
  output logic                  commit_valid_o,
  input  logic                  commit_ready_i,
  output backend_pkg::reg_idx_t commit_rd_idx_o,
  output backend_pkg::xlen_t    commit_value_o
);
  import backend_pkg::*;

  // Result bus, ALU -> reorder buffer
  logic                         cdb_valid;
  logic [$clog2(ROB_DEPTH)-1:0] cdb_tag;
  xlen_t                        cdb_value;

  rename_if    #(.ROB_DEPTH(ROB_DEPTH)) u_rename_if ();
  rob_alloc_if #(.ROB_DEPTH(ROB_DEPTH)) u_alloc_if ();
  exec_if      #(.ROB_DEPTH(ROB_DEPTH)) u_exec_if ();
  commit_if    #(.ROB_DEPTH(ROB_DEPTH)) u_commit_if ();

  // --------------------------------------------------
  // Issue -> ALU -> reorder buffer -> register file
  // --------------------------------------------------
  issue_stage #(.ROB_DEPTH(ROB_DEPTH)) u_issue_stage (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .instr_valid_i(instr_valid_i),
    .instr_ready_o(instr_ready_o),
    .instr_i      (instr_i),
    .rename_o     (u_rename_if.issue),
    .alloc_o      (u_alloc_if.issue),
    .exec_o       (u_exec_if.issue)
  );

  int_regfile #(.ROB_DEPTH(ROB_DEPTH)) u_int_regfile (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .rename_i(u_rename_if.regfile),
    .commit_i(u_commit_if.regfile)
  );

  alu_unit #(.ROB_DEPTH(ROB_DEPTH)) u_alu_unit (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .exec_i     (u_exec_if.alu),
    .cdb_valid_o(cdb_valid),
    .cdb_tag_o  (cdb_tag),
    .cdb_value_o(cdb_value)
  );

  reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_reorder_buffer (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .alloc_i        (u_alloc_if.rob),
    .cdb_valid_i    (cdb_valid),
    .cdb_tag_i      (cdb_tag),
    .cdb_value_i    (cdb_value),
    .commit_o       (u_commit_if.rob),
    .commit_valid_o (commit_valid_o),
    .commit_ready_i (commit_ready_i),
    .commit_rd_idx_o(commit_rd_idx_o),
    .commit_value_o (commit_value_o)
  );

endmodule

`default_nettype wire

// ==== design/backend_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

// Issue stage <-> register status and values
interface rename_if #(
  parameter int unsigned ROB_DEPTH = 8
);
  import backend_pkg::*;

  localparam int unsigned TAG_W = $clog2(ROB_DEPTH);

  logic             rename_valid;
  reg_idx_t         rd_idx;
  logic [TAG_W-1:0] tag;
  reg_idx_t         rs1_idx;
  reg_idx_t         rs2_idx;
  logic             rs1_busy;
  logic [TAG_W-1:0] rs1_tag;
  xlen_t            rs1_value;
  logic             rs2_busy;
  logic [TAG_W-1:0] rs2_tag;
  xlen_t            rs2_value;

  modport issue (
    output rename_valid, rd_idx, tag, rs1_idx, rs2_idx,
    input  rs1_busy, rs1_tag, rs1_value, rs2_busy, rs2_tag, rs2_value
  );

  modport regfile (
    input  rename_valid, rd_idx, tag, rs1_idx, rs2_idx,
    output rs1_busy, rs1_tag, rs1_value, rs2_busy, rs2_tag, rs2_value
  );
endinterface

// Issue stage <-> reorder buffer allocation and operand lookup
interface rob_alloc_if #(
  parameter int unsigned ROB_DEPTH = 8
);
  import backend_pkg::*;

  localparam int unsigned TAG_W = $clog2(ROB_DEPTH);

  logic             alloc_valid;
  logic             alloc_ready;
  reg_idx_t         alloc_rd_idx;
  logic [TAG_W-1:0] tail_tag;
  logic [TAG_W-1:0] rs1_tag;
  logic [TAG_W-1:0] rs2_tag;
  logic             rs1_done;
  xlen_t            rs1_value;
  logic             rs2_done;
  xlen_t            rs2_value;

  modport issue (
    output alloc_valid, alloc_rd_idx, rs1_tag, rs2_tag,
    input  alloc_ready, tail_tag, rs1_done, rs1_value, rs2_done, rs2_value
  );

  modport rob (
    input  alloc_valid, alloc_rd_idx, rs1_tag, rs2_tag,
    output alloc_ready, tail_tag, rs1_done, rs1_value, rs2_done, rs2_value
  );
endinterface

// Issue stage -> ALU, no back-pressure
interface exec_if #(
  parameter int unsigned ROB_DEPTH = 8
);
  import backend_pkg::*;

  localparam int unsigned TAG_W = $clog2(ROB_DEPTH);

  logic             valid;
  alu_op_e          op;
  xlen_t            operand_a;
  xlen_t            operand_b;
  logic [TAG_W-1:0] tag;

  modport issue (output valid, op, operand_a, operand_b, tag);
  modport alu   (input  valid, op, operand_a, operand_b, tag);
endinterface

// Reorder buffer retirement -> register file
interface commit_if #(
  parameter int unsigned ROB_DEPTH = 8
);
  import backend_pkg::*;

  localparam int unsigned TAG_W = $clog2(ROB_DEPTH);

  logic             valid;
  reg_idx_t         rd_idx;
  xlen_t            value;
  logic [TAG_W-1:0] tag;

  modport rob     (output valid, rd_idx, value, tag);
  modport regfile (input  valid, rd_idx, value, tag);
endinterface

`default_nettype wire

// ==== design/backend_pkg.sv ====
`default_nettype none

package backend_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------
  localparam int unsigned XLEN        = 32;
  localparam int unsigned ILEN        = 32;
  localparam int unsigned REG_IDX_LEN = 5;
  localparam int unsigned REG_NUM     = 32;

  typedef logic [XLEN-1:0]        xlen_t;
  typedef logic [ILEN-1:0]        instr_t;
  typedef logic [REG_IDX_LEN-1:0] reg_idx_t;

  // --------------------------------------------------
  // ALU operations
  // --------------------------------------------------
  // PASS_B forwards operand B, used by LUI
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLT,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_PASS_B
  } alu_op_e;

  // --------------------------------------------------
  // Major opcodes, instr[6:0]
  // --------------------------------------------------
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPCODE_LUI    = 7'b0110111;

endpackage

`default_nettype wire

// ==== design/int_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_regfile #(
  parameter int unsigned ROB_DEPTH = 8
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  rename_if.regfile  rename_i,
  commit_if.regfile  commit_i
);
  import backend_pkg::*;

  localparam int unsigned TAG_W = $clog2(ROB_DEPTH);

  xlen_t              value_q [REG_NUM];
  logic [REG_NUM-1:0] busy_q;
  logic [TAG_W-1:0]   tag_q [REG_NUM];

  logic rename_en;
  logic commit_en;
  logic clear_busy;

  // x0 is never renamed and never written
  assign rename_en = rename_i.rename_valid && (rename_i.rd_idx != '0);
  assign commit_en = commit_i.valid && (commit_i.rd_idx != '0);

  // Only the youngest producer clears busy, a same-cycle rename wins
  assign clear_busy = commit_en && (tag_q[commit_i.rd_idx] == commit_i.tag) &&
                      !(rename_en && (rename_i.rd_idx == commit_i.rd_idx));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= '0;
      for (int i = 0; i < REG_NUM; i++) begin
        value_q[i] <= '0;
      end
    end else begin
      if (commit_en) begin
        value_q[commit_i.rd_idx] <= commit_i.value;
      end
      if (clear_busy) begin
        busy_q[commit_i.rd_idx] <= 1'b0;
      end
      if (rename_en) begin
        busy_q[rename_i.rd_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rename_en) begin
      tag_q[rename_i.rd_idx] <= rename_i.tag;
    end
  end

  // Read ports
  assign rename_i.rs1_busy  = busy_q[rename_i.rs1_idx];
  assign rename_i.rs1_tag   = tag_q[rename_i.rs1_idx];
  assign rename_i.rs1_value = value_q[rename_i.rs1_idx];
  assign rename_i.rs2_busy  = busy_q[rename_i.rs2_idx];
  assign rename_i.rs2_tag   = tag_q[rename_i.rs2_idx];
  assign rename_i.rs2_value = value_q[rename_i.rs2_idx];

endmodule

`default_nettype wire

// ==== design/issue_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_stage #(
  parameter int unsigned ROB_DEPTH = 8
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                instr_valid_i,
  output logic                instr_ready_o,
  input  backend_pkg::instr_t instr_i,
  rename_if.issue             rename_o,
  rob_alloc_if.issue          alloc_o,
  exec_if.issue               exec_o
);
  import backend_pkg::*;

  localparam int unsigned TAG_W = $clog2(ROB_DEPTH);

  instr_t           instr_q;
  logic             full_q;
  logic             active_q;
  logic             dispatch;
  logic             operands_ok;
  logic [TAG_W-1:0] disp_tag;

  alu_op_e          op;
  reg_idx_t         rd_idx;
  xlen_t            imm;
  logic             use_rs1;
  logic             use_rs2;
  logic             use_imm;
  logic             legal;
  xlen_t            rs1_val;
  xlen_t            rs2_val;

  // --------------------------------------------------
  // Input register
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      full_q   <= 1'b0;
      active_q <= 1'b0;
    end else begin
      active_q <= 1'b1;
      if (instr_ready_o) begin
        full_q <= instr_valid_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_valid_i && instr_ready_o) begin
      instr_q <= instr_i;
    end
  end

  // Refill in the same cycle as dispatch
  assign instr_ready_o = active_q && (!full_q || dispatch);

  // --------------------------------------------------
  // Decoder
  // --------------------------------------------------
  always_comb begin
    op      = ALU_ADD;
    imm     = {{20{instr_q[31]}}, instr_q[31:20]};
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    use_imm = 1'b0;
    legal   = 1'b1;
    case (instr_q[6:0])
      OPCODE_OP: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        case (instr_q[14:12])
          3'b000:  op = instr_q[30] ? ALU_SUB : ALU_ADD;
          3'b001:  op = ALU_SLL;
          3'b010:  op = ALU_SLT;
          3'b100:  op = ALU_XOR;
          3'b101:  op = ALU_SRL;
          3'b110:  op = ALU_OR;
          3'b111:  op = ALU_AND;
          default: legal = 1'b0;
        endcase
        // funct7 is zero except for SUB
        if (instr_q[31:25] != 7'b0 &&
            !(instr_q[31:25] == 7'b0100000 && instr_q[14:12] == 3'b000)) begin
          legal = 1'b0;
        end
      end
      OPCODE_OP_IMM: begin
        use_rs1 = 1'b1;
        use_imm = 1'b1;
        case (instr_q[14:12])
          3'b000:  op = ALU_ADD;
          3'b010:  op = ALU_SLT;
          3'b100:  op = ALU_XOR;
          3'b110:  op = ALU_OR;
          3'b111:  op = ALU_AND;
          default: legal = 1'b0;
        endcase
      end
      OPCODE_LUI: begin
        op      = ALU_PASS_B;
        imm     = {instr_q[31:12], 12'b0};
        use_imm = 1'b1;
      end
      default: legal = 1'b0;
    endcase
    // Unsupported: x0 <- x0 + x0
    if (!legal) begin
      op      = ALU_ADD;
      use_rs1 = 1'b0;
      use_rs2 = 1'b0;
      use_imm = 1'b0;
    end
  end

  assign rd_idx = legal ? instr_q[11:7] : '0;

  // --------------------------------------------------
  // Operand selection
  // --------------------------------------------------
  // Unused sources read x0, which is never busy
  assign rename_o.rs1_idx = use_rs1 ? instr_q[19:15] : '0;
  assign rename_o.rs2_idx = use_rs2 ? instr_q[24:20] : '0;
  assign alloc_o.rs1_tag  = rename_o.rs1_tag;
  assign alloc_o.rs2_tag  = rename_o.rs2_tag;

  assign rs1_val = rename_o.rs1_busy ? alloc_o.rs1_value : rename_o.rs1_value;
  assign rs2_val = rename_o.rs2_busy ? alloc_o.rs2_value : rename_o.rs2_value;

  assign operands_ok = (!rename_o.rs1_busy || alloc_o.rs1_done) &&
                       (!rename_o.rs2_busy || alloc_o.rs2_done);

  // --------------------------------------------------
  // Dispatch
  // --------------------------------------------------
  assign disp_tag = alloc_o.tail_tag;
  assign dispatch = alloc_o.alloc_valid && alloc_o.alloc_ready;

  assign alloc_o.alloc_valid  = full_q && operands_ok;
  assign alloc_o.alloc_rd_idx = rd_idx;

  assign rename_o.rename_valid = dispatch;
  assign rename_o.rd_idx       = rd_idx;
  assign rename_o.tag          = disp_tag;

  assign exec_o.valid     = dispatch;
  assign exec_o.op        = op;
  assign exec_o.operand_a = rs1_val;
  assign exec_o.operand_b = use_imm ? imm : rs2_val;
  assign exec_o.tag       = disp_tag;

endmodule

`default_nettype wire

// ==== design/reorder_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer #(
  parameter int unsigned ROB_DEPTH = 8
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  rob_alloc_if.rob                     alloc_i,
  input  logic                         cdb_valid_i,
  input  logic [$clog2(ROB_DEPTH)-1:0] cdb_tag_i,
  input  backend_pkg::xlen_t           cdb_value_i,
  commit_if.rob                        commit_o,
  output logic                         commit_valid_o,
  input  logic                         commit_ready_i,
  output backend_pkg::reg_idx_t        commit_rd_idx_o,
  output backend_pkg::xlen_t           commit_value_o
);
  import backend_pkg::*;

  localparam int unsigned    TAG_W      = $clog2(ROB_DEPTH);
  localparam logic [TAG_W:0] FULL_COUNT = (TAG_W + 1)'(ROB_DEPTH);

  // Entry storage
  reg_idx_t             rd_q [ROB_DEPTH];
  xlen_t                value_q [ROB_DEPTH];
  logic [ROB_DEPTH-1:0] done_q;

  // Circular pointers, power-of-two depth wraps for free
  logic [TAG_W-1:0]     head_q;
  logic [TAG_W-1:0]     tail_q;
  logic [TAG_W:0]       count_q;

  logic                 alloc_fire;
  logic                 retire;

  assign alloc_i.alloc_ready = (count_q != FULL_COUNT);
  assign alloc_i.tail_tag    = tail_q;
  assign alloc_fire          = alloc_i.alloc_valid && alloc_i.alloc_ready;

  assign commit_valid_o = (count_q != '0) && done_q[head_q];
  assign retire         = commit_valid_o && commit_ready_i;

  // --------------------------------------------------
  // Pointers and occupancy
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (alloc_fire) begin
        tail_q <= tail_q + 1'b1;
      end
      if (retire) begin
        head_q <= head_q + 1'b1;
      end
      case ({alloc_fire, retire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // --------------------------------------------------
  // Entry state
  // --------------------------------------------------
  // A result never targets the entry being allocated
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      done_q <= '0;
    end else begin
      if (alloc_fire) begin
        done_q[tail_q] <= 1'b0;
      end
      if (cdb_valid_i) begin
        done_q[cdb_tag_i] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (alloc_fire) begin
      rd_q[tail_q] <= alloc_i.alloc_rd_idx;
    end
    if (cdb_valid_i) begin
      value_q[cdb_tag_i] <= cdb_value_i;
    end
  end

  // Operand lookup for the issue stage
  assign alloc_i.rs1_done  = done_q[alloc_i.rs1_tag];
  assign alloc_i.rs1_value = value_q[alloc_i.rs1_tag];
  assign alloc_i.rs2_done  = done_q[alloc_i.rs2_tag];
  assign alloc_i.rs2_value = value_q[alloc_i.rs2_tag];

  // --------------------------------------------------
  // In-order retirement
  // --------------------------------------------------
  assign commit_rd_idx_o = rd_q[head_q];
  assign commit_value_o  = value_q[head_q];

  // Register file sees only completed handshakes
  assign commit_o.valid  = retire;
  assign commit_o.rd_idx = rd_q[head_q];
  assign commit_o.value  = value_q[head_q];
  assign commit_o.tag    = head_q;

endmodule

`default_nettype wire

// ==== flist.f ====
design/backend_pkg.sv
design/backend_ifs.sv
design/issue_stage.sv
design/int_regfile.sv
design/alu_unit.sv
design/reorder_buffer.sv
design/backend.sv
sim/backend_asserts.sv
sim/tb_backend.sv

// ==== sim/backend_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module backend_assertions #(
  parameter int unsigned ROB_DEPTH = 8
) (
  input logic                  clk_i,
  input logic                  rst_n_i,
  input logic                  instr_valid_i,
  input logic                  instr_ready_o,
  input logic                  commit_valid_o,
  input logic                  commit_ready_i,
  input backend_pkg::reg_idx_t commit_rd_idx_o,
  input backend_pkg::xlen_t    commit_value_o
);

  int unsigned error_count = 0;
  int unsigned outstanding;

  // Accepted but not yet committed
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + (instr_valid_i && instr_ready_o)
                                 - (commit_valid_o && commit_ready_i);
    end
  end

  commit_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    commit_valid_o && !commit_ready_i |=>
      commit_valid_o && $stable(commit_rd_idx_o) && $stable(commit_value_o))
  else begin
    $error("commit outputs changed while stalled");
    error_count++;
  end

  reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i |=> !commit_valid_o && !instr_ready_o)
  else begin
    $error("commit_valid_o or instr_ready_o high during reset");
    error_count++;
  end

  outstanding_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    outstanding <= ROB_DEPTH + 1)
  else begin
    $error("more instructions in flight than the buffer and input register hold");
    error_count++;
  end

endmodule

bind backend backend_assertions #(.ROB_DEPTH(ROB_DEPTH)) i_asserts (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .instr_valid_i  (instr_valid_i),
  .instr_ready_o  (instr_ready_o),
  .commit_valid_o (commit_valid_o),
  .commit_ready_i (commit_ready_i),
  .commit_rd_idx_o(commit_rd_idx_o),
  .commit_value_o (commit_value_o)
);

`default_nettype wire

// ==== sim/tb_backend.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_backend;
  import backend_pkg::*;

  localparam int unsigned ROB_DEPTH    = 8;
  localparam int unsigned CLK_PERIOD   = 20;
  localparam int unsigned RESET_CYCLES = 10;

  // Instructions sent by each test
  localparam int unsigned N_IMM   = 24;
  localparam int unsigned N_SEED  = 2 * (REG_NUM - 1);
  localparam int unsigned N_OP    = 40;
  localparam int unsigned N_CHAIN = 32;
  localparam int unsigned N_ZERO  = 6;
  localparam int unsigned N_FILL  = 12;
  localparam int unsigned N_MIXED = 40;
  localparam int unsigned N_TOTAL = 1 + N_IMM + N_SEED + N_OP + N_CHAIN +
                                    N_ZERO + N_FILL + N_MIXED;
  localparam int unsigned WATCHDOG_TIME = (RESET_CYCLES + 40 * N_TOTAL) * CLK_PERIOD;

  typedef enum {READY_ALWAYS, READY_HOLD, READY_RANDOM} ready_mode_e;

  logic        clk;
  logic        rst_n;
  logic        instr_valid;
  logic        instr_ready;
  instr_t      instr;
  logic        commit_valid;
  logic        commit_ready;
  reg_idx_t    commit_rd_idx;
  xlen_t       commit_value;

  // Architectural model and expected commit stream
  xlen_t       arch_regs [REG_NUM];
  reg_idx_t    exp_rd [$];
  xlen_t       exp_value [$];

  logic [31:0] stim_state;
  logic [31:0] ready_state;
  ready_mode_e ready_mode;
  int unsigned errors;
  int unsigned commits;
  int unsigned tests_passed;
  int unsigned tests_failed;
  int unsigned test_start_errors;

  // ADDI, SLTI, XORI, ORI, ANDI
  logic [2:0]  imm_funct3 [5] = '{3'b000, 3'b010, 3'b100, 3'b110, 3'b111};

  backend #(.ROB_DEPTH(ROB_DEPTH)) i_dut (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .instr_valid_i  (instr_valid),
    .instr_ready_o  (instr_ready),
    .instr_i        (instr),
    .commit_valid_o (commit_valid),
    .commit_ready_i (commit_ready),
    .commit_rd_idx_o(commit_rd_idx),
    .commit_value_o (commit_value)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // --------------------------------------------------
  // Random numbers and instruction encoding
  // --------------------------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic [31:0] rand32();
    stim_state = xorshift(stim_state);
    return stim_state;
  endfunction

  // Any register but x0
  function automatic reg_idx_t rand_reg();
    return reg_idx_t'(1 + rand32() % 31);
  endfunction

  function automatic instr_t enc_r(input logic [6:0] funct7, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input logic [2:0] funct3,
                                   input reg_idx_t rd);
    return {funct7, rs2, rs1, funct3, rd, OPCODE_OP};
  endfunction

  function automatic instr_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                   input logic [2:0] funct3, input reg_idx_t rd);
    return {imm, rs1, funct3, rd, OPCODE_OP_IMM};
  endfunction

  function automatic instr_t enc_u(input logic [19:0] imm, input reg_idx_t rd);
    return {imm, rd, OPCODE_LUI};
  endfunction

  function automatic instr_t random_instr(input reg_idx_t rs1, input bit with_lui);
    logic [31:0] r;
    logic [2:0]  f3;
    reg_idx_t    rd;
    r  = rand32();
    rd = rand_reg();
    if (with_lui && r[1:0] == 2'b00) begin
      return enc_u(r[31:12], rd);
    end
    if (r[2]) begin
      return enc_i(r[31:20], rs1, imm_funct3[r[5:3] % 5], rd);
    end
    f3 = r[8:6];
    return enc_r((f3 == 3'b000 && r[9]) ? 7'b0100000 : 7'b0000000,
                 r[14:10], rs1, f3, rd);
  endfunction

  // --------------------------------------------------
  // Reference model from the ISA rules
  // --------------------------------------------------
  function automatic void model_exec(input instr_t ins, output reg_idx_t rd,
                                     output xlen_t value);
    xlen_t a;
    xlen_t b;
    xlen_t imm;
    a     = arch_regs[ins[19:15]];
    b     = arch_regs[ins[24:20]];
    imm   = {{20{ins[31]}}, ins[31:20]};
    rd    = ins[11:7];
    value = '0;
    case (ins[6:0])
      OPCODE_LUI: value = {ins[31:12], 12'h000};
      OPCODE_OP_IMM: begin
        case (ins[14:12])
          3'b000:  value = a + imm;
          3'b010:  value = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
          3'b100:  value = a ^ imm;
          3'b110:  value = a | imm;
          3'b111:  value = a & imm;
          default: rd = '0;
        endcase
      end
      OPCODE_OP: begin
        // SLTU and other unsupported funct3 values retire as no-ops
        case (ins[14:12])
          3'b000:  value = ins[30] ? a - b : a + b;
          3'b001:  value = a << b[4:0];
          3'b010:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          3'b100:  value = a ^ b;
          3'b101:  value = a >> b[4:0];
          3'b110:  value = a | b;
          3'b111:  value = a & b;
          default: rd = '0;
        endcase
      end
      default: rd = '0;
    endcase
  endfunction

  function automatic int unsigned total_errors();
    return errors + i_dut.i_asserts.error_count;
  endfunction

  // --------------------------------------------------
  // Driver tasks
  // --------------------------------------------------
  task automatic send(input instr_t ins);
    reg_idx_t rd;
    xlen_t    value;
    @(negedge clk);
    instr_valid = 1'b1;
    instr       = ins;
    while (!instr_ready) begin
      @(negedge clk);
    end
    // Accepted at the next rising edge
    model_exec(ins, rd, value);
    exp_rd.push_back(rd);
    exp_value.push_back(value);
    if (rd != '0) begin
      arch_regs[rd] = value;
    end
  endtask

  task automatic drain();
    @(negedge clk);
    instr_valid = 1'b0;
    while (exp_rd.size() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic start_test();
    test_start_errors = total_errors();
  endtask

  task automatic end_test(input string name);
    int unsigned failures;
    drain();
    failures = total_errors() - test_start_errors;
    if (failures == 0) begin
      tests_passed++;
      $display("Test %-14s ok", name);
    end else begin
      tests_failed++;
      $display("Test %-14s failed with %0d errors", name, failures);
    end
  endtask

  task automatic check_commit();
    commits++;
    assert (exp_rd.size() != 0) else begin
      $display("Error at %0t: commit with no instruction outstanding", $time);
      errors++;
    end
    if (exp_rd.size() != 0) begin
      assert (commit_rd_idx == exp_rd[0]) else begin
        $display("Mismatch at %0t: commit_rd_idx_o expected %0d, actual %0d",
                 $time, exp_rd[0], commit_rd_idx);
        errors++;
      end
      assert (commit_value == exp_value[0]) else begin
        $display("Mismatch at %0t: commit_value_o expected %h, actual %h",
                 $time, exp_value[0], commit_value);
        errors++;
      end
      void'(exp_rd.pop_front());
      void'(exp_value.pop_front());
    end
  endtask

  // Commit side picks ready and checks the handshake of the coming edge
  always @(negedge clk) begin
    ready_state = xorshift(ready_state);
    case (ready_mode)
      READY_HOLD:   commit_ready = 1'b0;
      READY_RANDOM: commit_ready = ready_state[7];
      default:      commit_ready = 1'b1;
    endcase
    if (rst_n && commit_valid && commit_ready) begin
      check_commit();
    end
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_TIME);
    $display("SOME TESTS FAILED");
    $finish;
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    logic [31:0] r;
    reg_idx_t    prev;
    instr_t      ins;
    clk          = 1'b0;
    rst_n        = 1'b0;
    instr_valid  = 1'b0;
    instr        = '0;
    commit_ready = 1'b1;
    ready_mode   = READY_ALWAYS;
    stim_state   = 32'hf6c2a6aa;
    ready_state  = 32'hf6c2a6aa;
    errors       = 0;
    commits      = 0;
    tests_passed = 0;
    tests_failed = 0;
    foreach (arch_regs[i]) begin
      arch_regs[i] = '0;
    end
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    start_test();
    assert (!commit_valid) else begin
      $display("Error at %0t: commit_valid_o high right after reset", $time);
      errors++;
    end
    send(enc_r(7'b0000000, 5'd3, 5'd2, 3'b000, 5'd1));
    end_test("reset_zero");

    start_test();
    repeat (N_IMM / 6) begin
      r = rand32();
      send(enc_u(r[31:12], rand_reg()));
      for (int k = 0; k < 5; k++) begin
        r = rand32();
        send(enc_i(r[11:0], r[16:12], imm_funct3[k], rand_reg()));
      end
    end
    end_test("lui_op_imm");

    // Random contents in every register before each OP in turn
    start_test();
    for (int i = 1; i < REG_NUM; i++) begin
      r = rand32();
      send(enc_u(r[31:12], reg_idx_t'(i)));
      send(enc_i(r[11:0], reg_idx_t'(i), 3'b000, reg_idx_t'(i)));
    end
    for (int round = 0; round < N_OP / 8; round++) begin
      for (int f3 = 0; f3 < 8; f3++) begin
        r = rand32();
        send(enc_r((f3 == 0 && round[0]) ? 7'b0100000 : 7'b0000000,
                   r[4:0], r[9:5], 3'(f3), rand_reg()));
      end
    end
    end_test("op_reg");

    start_test();
    repeat (N_CHAIN / 8) begin
      prev = rand_reg();
      repeat (8) begin
        ins  = random_instr(prev, 1'b0);
        prev = ins[11:7];
        send(ins);
      end
    end
    end_test("dep_chains");

    start_test();
    r = rand32();
    send(enc_i(r[11:0], 5'd3, 3'b000, 5'd0));
    send(enc_r(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd0));
    send(enc_u(r[31:12], 5'd0));
    send(enc_r(7'b0000000, 5'd0, 5'd0, 3'b000, 5'd9));
    send(enc_i(12'h005, 5'd0, 3'b000, 5'd10));
    send(enc_r(7'b0000000, 5'd4, 5'd0, 3'b110, 5'd11)); // OR x11, x0, x4
    end_test("x0_writes");

    // Hold commits until the input side backs up and release them at random after
    start_test();
    ready_mode = READY_HOLD;
    fork
      begin
        repeat (N_FILL) send(random_instr(rand_reg(), 1'b1));
      end
      begin
        repeat (8 * ROB_DEPTH) @(negedge clk);
        assert (!instr_ready) else begin
          $display("Error at %0t: instr_ready_o still high with commits stalled", $time);
          errors++;
        end
        assert (commit_valid) else begin
          $display("Error at %0t: commit_valid_o low with a full buffer", $time);
          errors++;
        end
        ready_mode = READY_RANDOM;
      end
    join
    repeat (N_MIXED) send(random_instr(rand_reg(), 1'b1));
    end_test("backpressure");

    repeat (5) @(negedge clk);
    $display("Tests: %0d passed, %0d failed; commits checked: %0d; errors: %0d",
             tests_passed, tests_failed, commits, total_errors());
    if (tests_failed == 0 && total_errors() == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
